//--- mx5k_bus.f
+incdir+common
+incdir+dv
common/mx5k_pkg.sv
logic/mem_map_decoder.sv
io_ports/io_ports.sv
logic/cpu_data_mux.sv
logic/mx5k_main_bus.sv
dv/mx5k_main_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the main bus testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ns --top-module mx5k_main_bus_tb \
    -f mx5k_bus.f -o mx5k_sim
out=$(./obj_dir/mx5k_sim)
echo "$out"
if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- dv/mx5k_vectors.svh
// main bus test vectors
`ifndef MX5K_VECTORS_SVH
`define MX5K_VECTORS_SVH

// columns: addr, rnw, vma, write data, pal_cs, cpu_cen, kind, name
task automatic load_vectors;
    add_row(16'h5123, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "bank0_page5");  // reset bank
    add_row(16'h0040, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "gfx_page0");
    add_row(16'h1234, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "gfx_page1");
    add_row(16'h2abc, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "gfx_page2");
    add_row(16'h3456, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "ram_page3");
    add_row(16'h4008, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "io_reg2_open");
    add_row(16'h7f00, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "rom_page7_fixed");
    add_row(16'hb456, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "rom_page_b");
    add_row(16'hc123, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "rom_page_c");
    add_row(16'hd000, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "rom_page_d");
    add_row(16'he800, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "rom_page_e");
    add_row(16'hffff, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "rom_page_f");
    add_row(16'h8000, 1'b0, 1'b1, 8'h33, 1'b0, 1'b1, K_RD,  "rom_write_nosel");
    add_row(16'h9000, 1'b1, 1'b0, 8'h00, 1'b0, 1'b1, K_RD,  "rom_vma_low");
    // bank register, each value then a page-5 read
    add_row(16'h4010, 1'b0, 1'b1, 8'h01, 1'b0, 1'b1, K_WR,  "bank_wr1");
    add_row(16'h5abc, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "bank1_page5");
    add_row(16'h4010, 1'b0, 1'b1, 8'h02, 1'b0, 1'b1, K_WR,  "bank_wr2");
    add_row(16'h5001, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "bank2_page5");
    add_row(16'h4010, 1'b0, 1'b1, 8'h03, 1'b0, 1'b1, K_WR,  "bank_wr3");
    add_row(16'h5fff, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "bank3_page5");
    add_row(16'h4010, 1'b0, 1'b1, 8'hfc, 1'b0, 1'b1, K_WR,  "bank_wr0");  // upper bits dropped
    add_row(16'h5777, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "bank0_again");
    add_row(16'h6123, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "page6_fixed");
    // cabinet ports and dips
    add_row(16'h4000, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "in_port0");
    add_row(16'h4001, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "in_port1");
    add_row(16'h4002, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "in_port2");
    add_row(16'h4003, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_RD,  "in_port3");
    add_row(16'h4004, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_DIP, "dip_b_read");
    add_row(16'h4005, 1'b1, 1'b1, 8'h00, 1'b0, 1'b1, K_DIP, "dip_a_read");
    // palette select against rom and open bus
    add_row(16'h5200, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, K_RD,  "pal_vs_rom");
    add_row(16'ha000, 1'b1, 1'b0, 8'h00, 1'b1, 1'b1, K_RD,  "pal_unmapped");
    // sound cpu link
    add_row(16'h4014, 1'b0, 1'b1, 8'h5a, 1'b0, 1'b1, K_WR,  "latch_wr");
    add_row(16'h4018, 1'b0, 1'b1, 8'h00, 1'b0, 1'b1, K_IRQ, "irq_pulse");
    add_row(16'h4014, 1'b0, 1'b1, 8'ha5, 1'b0, 1'b0, K_WR,  "latch_cen_low");
endtask

`endif

//--- dv/mx5k_main_bus_tb.sv
// main bus testbench
`timescale 1ns/1ns
`default_nettype none

`include "mx5k_consts.svh"

module mx5k_main_bus_tb;
    import mx5k_pkg::*;

    localparam logic [1:0] K_RD  = 2'd0;   // read, check sel, rom_addr, cpu_din
    localparam logic [1:0] K_DIP = 2'd1;   // read plus internal port register
    localparam logic [1:0] K_WR  = 2'd2;   // one-cycle write, check latch
    localparam logic [1:0] K_IRQ = 2'd3;   // strobe write, measure pulse

    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;
        logic        vma;
        logic [ 7:0] dout;
        logic        pal;      // pal_cs during the row
        logic        cen;
        logic [ 1:0] kind;
    } row_t;

    logic        clk;
    logic        rst;
    logic        cpu_cen;
    cpu_bus_t    cpu;
    cabinet_t    cab;
    dip_t        dip;
    logic [ 7:0] rom_data;
    logic [ 7:0] ram_dout;
    logic [ 7:0] gfx1_dout;
    logic [ 7:0] pal_dout;
    logic        pal_cs;
    mem_sel_t    sel;
    logic [15:0] rom_addr;
    logic [ 7:0] cpu_din;
    logic [ 7:0] snd_latch;
    logic        snd_irq;

    row_t        rows[$];
    string       names[$];
    logic [15:0] lfsr;
    logic [ 1:0] bank_m;    // expected bank register
    logic [ 7:0] latch_m;   // expected sound latch
    int          errors;
    int          checks;

    mx5k_main_bus u_mx5k_main_bus (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .cpu(cpu), .cab(cab), .dip(dip),
        .rom_data(rom_data), .ram_dout(ram_dout), .gfx1_dout(gfx1_dout),
        .pal_dout(pal_dout), .pal_cs(pal_cs), .sel(sel), .rom_addr(rom_addr),
        .cpu_din(cpu_din), .snd_latch(snd_latch), .snd_irq(snd_irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};   // one step per bit
        end
    endtask

    task automatic randomize_inputs;
        logic [31:0] v;
        get_bits(19, v);
        cab = v[18:0];
        get_bits(20, v);
        dip = v[19:0];
        get_bits(8, v);
        rom_data = v[7:0];
        get_bits(8, v);
        ram_dout = v[7:0];
        get_bits(8, v);
        gfx1_dout = v[7:0];
        get_bits(8, v);
        pal_dout = v[7:0];
    endtask

    task automatic add_row(input logic [15:0] addr, input logic rnw, input logic vma,
                           input logic [7:0] dout, input logic pal, input logic cen,
                           input logic [1:0] kind, input string name);
        rows.push_back({addr, rnw, vma, dout, pal, cen, kind});
        names.push_back(name);
    endtask

    `include "mx5k_vectors.svh"

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Error %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // page map: 0..2 video, 3 ram, 4 i/o, 5 up rom on valid reads
    function automatic mem_sel_t exp_sel(input row_t r);
        mem_sel_t s;
        s = '0;
        case (r.addr[15:12])
            4'd0, 4'd1, 4'd2: s.gfx1 = 1'b1;
            `MX5K_RAM_PAGE:   s.ram  = 1'b1;
            `MX5K_IO_PAGE:    s.io   = 1'b1;
            default:          s.rom  = r.rnw && r.vma;
        endcase
        return s;
    endfunction

    function automatic logic [15:0] exp_rom_addr(input row_t r);
        if (r.addr[15:12] >= `MX5K_FIXED_PAGE_MIN) begin
            return r.addr;   // fixed rom
        end
        return {r.addr[15], bank_m, r.addr[12:0]};
    endfunction

    // stick byte, direction pairs crossed
    function automatic logic [7:0] stick_byte(input logic [6:0] j);
        logic [7:0] b;
        b[7:6] = 2'b11;
        b[5:4] = j[5:4];
        b[3]   = j[2];
        b[2]   = j[3];
        b[1]   = j[0];
        b[0]   = j[1];
        return b;
    endfunction

    function automatic logic [7:0] input_byte(input logic [1:0] port);
        case (port)
            2'd0:    return {3'b111, cab.start, cab.service, cab.coin};
            2'd1:    return stick_byte(cab.joy1);
            2'd2:    return stick_byte(cab.joy2);
            default: return {2'b11, cab.joy2[6], cab.joy1[6], dip.dip_c};
        endcase
    endfunction

    function automatic logic [7:0] exp_din(input row_t r);
        mem_sel_t s;
        s = exp_sel(r);
        if (s.rom) return rom_data;
        if (s.ram) return ram_dout;
        if (r.pal) return pal_dout;
        if (s.io && r.addr[4:2] == `MX5K_REG_IN) return input_byte(r.addr[1:0]);
        if (s.gfx1) return gfx1_dout;
        return `MX5K_OPEN_BUS;   // dip register lands here too
    endfunction

    task automatic release_bus;
        cpu.rnw = 1'b1;   // back to reads
        cpu_cen = 1'b1;
    endtask

    task automatic apply_row(input int i);
        row_t  r;
        string n;
        int    waited;
        int    high;
        r = rows[i];
        n = names[i];
        randomize_inputs();
        cpu.addr = r.addr;
        cpu.rnw  = r.rnw;
        cpu.vma  = r.vma;
        cpu.dout = r.dout;
        pal_cs   = r.pal;
        cpu_cen  = r.cen;
        @(posedge clk);
        #1;
        case (r.kind)
            K_RD, K_DIP: begin
                // second cycle of the address, port register loaded
                check_value({n, " sel"}, 32'(exp_sel(r)), 32'(sel));
                check_value({n, " rom_addr"}, 32'(exp_rom_addr(r)), 32'(rom_addr));
                check_value({n, " cpu_din"}, 32'(exp_din(r)), 32'(cpu_din));
                if (r.kind == K_DIP) begin
                    check_value({n, " port_data"}, 32'(r.addr[0] ? dip.dip_a : dip.dip_b),
                                32'(u_mx5k_main_bus.u_io_ports.port_data));
                end
                @(posedge clk);
                #1;
            end
            K_WR: begin
                if (r.cen) begin   // write lands only with cen
                    case (r.addr[4:2])
                        `MX5K_REG_BANK:  bank_m  = r.dout[1:0];
                        `MX5K_REG_LATCH: latch_m = r.dout;
                        default: ;
                    endcase
                end
                release_bus();
                check_value({n, " snd_latch"}, 32'(latch_m), 32'(snd_latch));
                check_value({n, " snd_irq"}, 32'd0, 32'(snd_irq));
            end
            K_IRQ: begin
                release_bus();
                waited = 0;
                while (!snd_irq && waited < 8) begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
                if (!snd_irq) begin
                    $display("%s: snd_irq never rose after the strobe write", n);
                    errors++;
                end else begin
                    high = 0;
                    while (snd_irq && high < 8) begin   // count cen cycles high
                        @(posedge clk);
                        #1;
                        high++;
                    end
                    check_value({n, " irq_cycles"}, 32'd1, 32'(high));
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        rst       = 1'b1;
        cpu_cen   = 1'b1;
        cpu       = '0;
        cpu.rnw   = 1'b1;
        cab       = '0;
        dip       = '0;
        rom_data  = '0;
        ram_dout  = '0;
        gfx1_dout = '0;
        pal_dout  = '0;
        pal_cs    = 1'b0;
        lfsr      = 16'd72;   // seed
        bank_m    = '0;
        latch_m   = '0;
        errors    = 0;
        checks    = 0;
        load_vectors();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/mx5k_main_bus.sv
// main cpu bus glue top
`timescale 1ns/1ns
`default_nettype none

module mx5k_main_bus (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_cen,
    input  mx5k_pkg::cpu_bus_t cpu,
    input  mx5k_pkg::cabinet_t cab,
    input  mx5k_pkg::dip_t     dip,
    // memory and video read data
    input  logic [ 7:0]        rom_data,
    input  logic [ 7:0]        ram_dout,
    input  logic [ 7:0]        gfx1_dout,
    input  logic [ 7:0]        pal_dout,
    input  logic               pal_cs,
    // selects and rom address
    output mx5k_pkg::mem_sel_t sel,
    output logic [15:0]        rom_addr,
    output logic [ 7:0]        cpu_din,
    // sound cpu link
    output logic [ 7:0]        snd_latch,
    output logic               snd_irq
);

    logic [1:0] bank;        // rom bank, io -> decoder
    logic [7:0] port_data;   // registered input read
    logic       in_sel;

    mem_map_decoder u_mem_map_decoder (
        .cpu      (cpu),
        .bank     (bank),
        .sel      (sel),
        .rom_addr (rom_addr)
    );

    io_ports u_io_ports (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .cpu       (cpu),
        .io_sel    (sel.io),
        .cab       (cab),
        .dip       (dip),
        .port_data (port_data),
        .in_sel    (in_sel),
        .bank      (bank),
        .snd_latch (snd_latch),
        .snd_irq   (snd_irq)
    );

    cpu_data_mux u_cpu_data_mux (
        .sel       (sel),
        .in_sel    (in_sel),
        .pal_cs    (pal_cs),
        .rom_data  (rom_data),
        .ram_dout  (ram_dout),
        .pal_dout  (pal_dout),
        .gfx1_dout (gfx1_dout),
        .port_data (port_data),
        .cpu_din   (cpu_din)
    );

endmodule

`default_nettype wire

//--- logic/cpu_data_mux.sv
// cpu read data mux
`timescale 1ns/1ns
`default_nettype none

`include "mx5k_consts.svh"

module cpu_data_mux (
    input  mx5k_pkg::mem_sel_t sel,
    input  logic               in_sel,
    input  logic               pal_cs,     // from the video chip
    input  logic [7:0]         rom_data,
    input  logic [7:0]         ram_dout,
    input  logic [7:0]         pal_dout,
    input  logic [7:0]         gfx1_dout,
    input  logic [7:0]         port_data,
    output logic [7:0]         cpu_din
);

    // fixed priority, rom first
    // kept combinational, cpu samples in the same cycle
    always_comb begin
        if (sel.rom) begin
            cpu_din = rom_data;
        end else if (sel.ram) begin
            cpu_din = ram_dout;
        end else if (pal_cs) begin
            // palette overlays the video window
            cpu_din = pal_dout;
        end else if (in_sel) begin
            cpu_din = port_data;   // registered port value
        end else if (sel.gfx1) begin
            cpu_din = gfx1_dout;
        end else begin
            // dip reads also land here, see below
            cpu_din = `MX5K_OPEN_BUS;
        end
    end

    // note: dip reads are only seen through port_data when in_sel is set,
    // so a dip access on its own shows open bus, as on the board

endmodule

`default_nettype wire

//--- io_ports/io_ports.sv
// i/o page ports and output latches
`timescale 1ns/1ns
`default_nettype none

`include "mx5k_consts.svh"

module io_ports (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_cen,
    input  mx5k_pkg::cpu_bus_t cpu,
    input  logic               io_sel,     // i/o page selected
    input  mx5k_pkg::cabinet_t cab,
    input  mx5k_pkg::dip_t     dip,
    output logic [7:0]         port_data,
    output logic               in_sel,     // input port read in progress
    output logic [1:0]         bank,
    output logic [7:0]         snd_latch,
    output logic               snd_irq
);
    import mx5k_pkg::*;

    cpu_addr_u   a;
    logic [2:0]  reg_code;
    logic [1:0]  port;
    logic        dip_sel;
    logic        wr;       // qualified write strobe

    // stick wiring swaps the two direction pairs
    function automatic logic [7:0] joy_bits(input logic [6:0] joy);
        logic [7:0] r;
        r = {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
        return r;
    endfunction

    assign a        = cpu.addr;
    assign reg_code = a.io.reg_code;
    assign port     = a.io.port;

    assign in_sel  = io_sel && (reg_code == `MX5K_REG_IN);
    assign dip_sel = io_sel && (reg_code == `MX5K_REG_DIP);
    assign wr      = cpu_cen && io_sel && !cpu.rnw;

    // read path, one clock behind the address
    always_ff @(posedge clk) begin
        port_data <= `MX5K_OPEN_BUS;   // idle value
        if (dip_sel) begin
            port_data <= port[0] ? dip.dip_a : dip.dip_b;
        end
        if (in_sel) begin
            case (port)
                `MX5K_PORT_SYS: begin
                    port_data <= {3'b111, cab.start, cab.service, cab.coin};
                end
                `MX5K_PORT_P1:  port_data <= joy_bits(cab.joy1);
                `MX5K_PORT_P2:  port_data <= joy_bits(cab.joy2);
                default: begin
                    // second buttons share the byte with dip c
                    port_data <= {2'b11, cab.joy2[6], cab.joy1[6], dip.dip_c};
                end
            endcase
        end
    end

    // write side, coin counters and watchdog not fitted
    always_ff @(posedge clk) begin
        if (rst) begin
            bank      <= '0;
            snd_latch <= '0;
            snd_irq   <= 1'b0;
        end else if (cpu_cen) begin
            snd_irq <= 1'b0;   // strobe lasts one cen
            if (wr) begin
                case (reg_code)
                    `MX5K_REG_BANK:  bank      <= cpu.dout[1:0];
                    `MX5K_REG_LATCH: snd_latch <= cpu.dout;
                    `MX5K_REG_IRQ:   snd_irq   <= 1'b1;   // data ignored
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_map_decoder.sv
// main cpu memory map decoder
`timescale 1ns/1ns
`default_nettype none

`include "mx5k_consts.svh"

module mem_map_decoder (
    input  mx5k_pkg::cpu_bus_t cpu,
    input  logic [ 1:0]        bank,     // from the i/o bank register
    output mx5k_pkg::mem_sel_t sel,
    output logic [15:0]        rom_addr
);
    import mx5k_pkg::*;

    cpu_addr_u   a;
    logic [ 3:0] page;
    logic        banked;   // page falls in the switched window

    assign a    = cpu.addr;
    assign page = a.mem.page;

    // page decode, same boundaries as the 051502 on the board
    always_comb begin
        // rom only drives the bus on valid reads
        sel.rom  = (page >= `MX5K_ROM_PAGE_MIN) && cpu.rnw && cpu.vma;
        sel.ram  = (page == `MX5K_RAM_PAGE);
        sel.gfx1 = (page <  `MX5K_GFX_PAGE_END);   // 0..2
        sel.io   = (page == `MX5K_IO_PAGE);
    end

    // 8 kB window below 0x6000 is switched by the bank register
    assign banked = page < `MX5K_FIXED_PAGE_MIN;

    always_comb begin
        if (banked) begin
            // bank replaces A[14:13]
            rom_addr = {a[15], bank, a[12:0]};
        end else begin
            rom_addr = a;   // fixed area, straight through
        end
    end

endmodule

`default_nettype wire

//--- common/mx5k_pkg.sv
// main bus types
`default_nettype none

package mx5k_pkg;

    // memory view of the cpu address, 4 kB pages
    typedef struct packed {
        logic [ 3:0] page;     // A[15:12]
        logic [11:0] offset;   // A[11:0]
    } addr_mem_t;

    // i/o view, only A[4:0] carry meaning on the i/o page
    typedef struct packed {
        logic [10:0] hi;       // page bits plus don't-care bits
        logic [ 2:0] reg_code; // A[4:2], 5D on the board
        logic [ 1:0] port;     // A[1:0]
    } addr_io_t;

    // one address word, two decodes
    typedef union packed {
        addr_mem_t mem;
        addr_io_t  io;
    } cpu_addr_u;

    // what the cpu puts on the bus each cycle
    typedef struct packed {
        cpu_addr_u   addr;
        logic        vma;      // valid memory address
        logic        rnw;      // low on writes
        logic [ 7:0] dout;     // write data
    } cpu_bus_t;

    // cabinet controls, all active low as wired
    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic [6:0] joy1;     // bit 6 is the second button
        logic [6:0] joy2;
        logic       service;
    } cabinet_t;

    // dip switch banks
    typedef struct packed {
        logic [7:0] dip_a;
        logic [7:0] dip_b;
        logic [3:0] dip_c;    // read through input port 3
    } dip_t;

    // chip selects, one-hot or none
    typedef struct packed {
        logic rom;
        logic ram;
        logic gfx1;
        logic io;
    } mem_sel_t;

endpackage

`default_nettype wire

//--- common/mx5k_consts.svh
// main bus constants
`ifndef MX5K_CONSTS_SVH
`define MX5K_CONSTS_SVH

// page boundaries, page = A[15:12]
`define MX5K_ROM_PAGE_MIN   4'd5   // rom reads from here up
`define MX5K_FIXED_PAGE_MIN 4'd6   // unbanked rom from here up
`define MX5K_RAM_PAGE       4'd3   // work ram
`define MX5K_GFX_PAGE_END   4'd3   // pages below go to the video chip
`define MX5K_IO_PAGE        4'd4   // cabinet, dips and output latches

// i/o register codes on A[4:2]
`define MX5K_REG_IN         3'd0   // input ports, port on A[1:0]
`define MX5K_REG_DIP        3'd1   // dip a/b, picked by A[0]
`define MX5K_REG_BANK       3'd4   // rom bank, data bits 1:0
`define MX5K_REG_LATCH      3'd5   // sound cpu latch
`define MX5K_REG_IRQ        3'd6   // sound cpu irq strobe

// input port numbers on A[1:0]
`define MX5K_PORT_SYS       2'd0   // start, service, coin
`define MX5K_PORT_P1        2'd1   // player 1 stick
`define MX5K_PORT_P2        2'd2   // player 2 stick
`define MX5K_PORT_EXTRA     2'd3   // buttons 2 and dip c

// value seen when nothing drives the bus
`define MX5K_OPEN_BUS       8'hff

`endif
